/* aes_config.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 peripheral configuration
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// bus widths of the AXI4-Lite slave port
`define AES_ADDR_W 8
`define AES_DATA_W 32

// a 128-bit key always takes ten rounds after the initial AddRoundKey
`define AES_ROUNDS 10

// register map, byte offsets
`define AES_REG_CTRL   8'h00 // bit 0 written as one starts a block
`define AES_REG_STATUS 8'h04 // bit 0 busy, bit 1 done
`define AES_REG_KEY0   8'h10 // key words 0 to 3 at 0x10 to 0x1c
`define AES_REG_PT0    8'h20 // plaintext words 0 to 3 at 0x20 to 0x2c
`define AES_REG_CT0    8'h30 // ciphertext words 0 to 3 at 0x30 to 0x3c

// response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

/* aes_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 shared types and S-box
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package aes_pkg;

  // a 128-bit value holds bytes in column order, S0,0 sits in bits 127:120
  // and word 0 in bits 127:96
  typedef struct packed {
    logic [127:0] key;       // cipher key, word 0 first
    logic [127:0] plaintext; // input block
  } aesReqT;

  typedef struct packed {
    logic [127:0] cipher; // output block after round ten
  } aesRespT;

  typedef enum logic {
    IDLE, // waiting for a start pulse
    RUN   // one round per clock
  } engineStateT;

  // register class of an AXI address, decode steers on this
  typedef enum logic [2:0] {
    CTRL,
    STATUS,
    KEY,
    PT,
    CT,
    NONE // outside the map, answers SLVERR
  } regSelT;

  // forward S-box from FIPS-197, row is the high nibble
  localparam logic [7:0] sboxTable [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  function automatic logic [7:0] sboxLookup(input logic [7:0] b);
    return sboxTable[b]; // plain table read, synthesizes to a 256x8 ROM
  endfunction

endpackage

`default_nettype wire

/* aes_reg_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES AXI4-Lite register decode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "aes_config.svh"

module aes_reg_decode (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      awvalid,
  output logic                           awready,
  input  wire logic [`AES_ADDR_W-1:0]    awaddr,
  input  wire logic                      wvalid,
  output logic                           wready,
  input  wire logic [`AES_DATA_W-1:0]    wdata,
  input  wire logic [`AES_DATA_W/8-1:0]  wstrb,
  output logic                           bvalid,
  input  wire logic                      bready,
  output logic [1:0]                     bresp,
  input  wire logic                      arvalid,
  output logic                           arready,
  input  wire logic [`AES_ADDR_W-1:0]    araddr,
  output logic                           rvalid,
  input  wire logic                      rready,
  output logic [`AES_DATA_W-1:0]         rdata,
  output logic [1:0]                     rresp,
  output logic                           start,
  output aes_pkg::aesReqT                req,
  input  wire logic                      busy,
  input  wire logic                      done,
  input  wire logic [127:0]              ctWords
);

  localparam logic [`AES_ADDR_W-1:0] ctrlAddr   = `AES_REG_CTRL;
  localparam logic [`AES_ADDR_W-1:0] statusAddr = `AES_REG_STATUS;
  localparam logic [`AES_ADDR_W-1:0] keyAddr    = `AES_REG_KEY0;
  localparam logic [`AES_ADDR_W-1:0] ptAddr     = `AES_REG_PT0;
  localparam logic [`AES_ADDR_W-1:0] ctAddr     = `AES_REG_CT0;

  aes_pkg::regSelT  wrSel, rdSel;    // register class of each channel's address
  logic             wrFire, rdFire;  // handshake completes this cycle
  logic [1:0]       wrIdx, rdIdx;    // word index inside a four-word block
  logic [`AES_DATA_W-1:0] rdNext;    // read mux output, registered into rdata

  // word-aligned addresses only, anything else falls out as NONE
  function automatic aes_pkg::regSelT classify(input logic [`AES_ADDR_W-1:0] a);
    if (a == ctrlAddr)                                         return aes_pkg::CTRL;
    if (a == statusAddr)                                       return aes_pkg::STATUS;
    if (a[1:0] != 2'b00)                                       return aes_pkg::NONE;
    if (a[`AES_ADDR_W-1:4] == keyAddr[`AES_ADDR_W-1:4])       return aes_pkg::KEY;
    if (a[`AES_ADDR_W-1:4] == ptAddr[`AES_ADDR_W-1:4])        return aes_pkg::PT;
    if (a[`AES_ADDR_W-1:4] == ctAddr[`AES_ADDR_W-1:4])        return aes_pkg::CT;
    return aes_pkg::NONE;
  endfunction

  // word i of a block lives in bits 127-32*i down
  function automatic logic [31:0] wordOf(input logic [127:0] v, input logic [1:0] i);
    return v[127 - 32*int'(i) -: 32];
  endfunction

  assign wrSel   = classify(awaddr);
  assign rdSel   = classify(araddr);
  assign wrIdx   = awaddr[3:2];
  assign rdIdx   = araddr[3:2];
  assign wrFire  = awready && awvalid && wvalid; // awready and wready rise together
  assign arready = !rvalid;                      // one read outstanding at a time
  assign rdFire  = arvalid && arready;

  always_comb begin
    case (rdSel)
      aes_pkg::STATUS: rdNext = {30'b0, done, busy};
      aes_pkg::KEY:    rdNext = wordOf(req.key, rdIdx);
      aes_pkg::PT:     rdNext = wordOf(req.plaintext, rdIdx);
      aes_pkg::CT:     rdNext = wordOf(ctWords, rdIdx);
      default:         rdNext = '0; // CTRL reads back zero, so does an unmapped address
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      start   <= 1'b0;
      req     <= '0;
    end else begin
      // one-cycle ready pulse once both halves of the write are presented
      awready <= !awready && !bvalid && awvalid && wvalid;
      wready  <= !awready && !bvalid && awvalid && wvalid;
      // the engine takes one block at a time, a second start is dropped here
      start   <= wrFire && (wrSel == aes_pkg::CTRL) && wdata[0] && !busy && !start;
      if (wrFire) begin
        bvalid <= 1'b1;
        bresp  <= (wrSel == aes_pkg::NONE) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
        for (int b = 0; b < `AES_DATA_W/8; b++) begin
          if (wstrb[b] && wrSel == aes_pkg::KEY)
            req.key[96 - 32*int'(wrIdx) + 8*b +: 8] <= wdata[8*b +: 8];
          if (wstrb[b] && wrSel == aes_pkg::PT)
            req.plaintext[96 - 32*int'(wrIdx) + 8*b +: 8] <= wdata[8*b +: 8];
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (rdFire) begin
        rvalid <= 1'b1;
        rdata  <= rdNext;
        rresp  <= (rdSel == aes_pkg::NONE) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // a response stays on the bus until the master takes it
  bHoldCheck: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid);
  rHoldCheck: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* aes_result.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES ciphertext capture and done flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module aes_result (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start,
  input  wire logic              cipherValid,
  input  wire aes_pkg::aesRespT  resp,
  output logic                   done,
  output logic [127:0]           ctWords
);

  logic [127:0] ctReg; // last finished block, word 0 in bits 127:96

  always_ff @(posedge clk) begin
    if (rst) begin
      ctReg <= '0; // host reads zero before the first block
    end else if (cipherValid) begin
      ctReg <= resp.cipher;
    end
  end

  // sticky until the host starts another block
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b0;
    end else if (cipherValid) begin
      done <= 1'b1;
    end
  end

  assign ctWords = ctReg;

  // the engine is busy at cipherValid so decode cannot start in that cycle
  noOverlapCheck: assert property (@(posedge clk) disable iff (rst)
    !(cipherValid && start));

endmodule

`default_nettype wire

/* aes_round_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 iterative round engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "aes_config.svh"

module aes_round_engine (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             start,
  input  wire aes_pkg::aesReqT  req,
  output logic                  busy,
  output logic                  cipherValid,
  output aes_pkg::aesRespT      resp
);

  aes_pkg::engineStateT stateQ;     // IDLE or RUN
  logic [3:0]           roundCnt;   // round computed in the current cycle, 1 to 10
  logic [127:0]         stateReg;   // AES state after the previous round
  logic [127:0]         roundKey;   // key of the previous round
  logic [7:0]           rcon;       // round constant for the key being derived
  logic [127:0]         nextKey;    // key of the current round
  logic [127:0]         shifted;    // state after SubBytes and ShiftRows
  logic [127:0]         roundOut;   // state after this round's AddRoundKey
  logic                 lastRound;  // round ten skips MixColumns

  // multiply by x in GF(2^8) modulo x^8+x^4+x^3+x+1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] subWord(input logic [31:0] w);
    return {aes_pkg::sboxLookup(w[31:24]), aes_pkg::sboxLookup(w[23:16]),
            aes_pkg::sboxLookup(w[15:8]), aes_pkg::sboxLookup(w[7:0])};
  endfunction

  function automatic logic [127:0] subBytes(input logic [127:0] s);
    logic [127:0] r;
    for (int i = 0; i < 16; i++)
      r[8*i +: 8] = aes_pkg::sboxLookup(s[8*i +: 8]);
    return r;
  endfunction

  // row r rotates left by r columns, byte (r,c) sits at bits 127-8*(4c+r)
  function automatic logic [127:0] shiftRows(input logic [127:0] s);
    logic [127:0] r;
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
    return r;
  endfunction

  function automatic logic [31:0] mixColumn(input logic [31:0] w);
    logic [7:0] a0, a1, a2, a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,  // 2 3 1 1
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,  // 1 2 3 1
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,  // 1 1 2 3
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)}; // 3 1 1 2
  endfunction

  function automatic logic [127:0] mixColumns(input logic [127:0] s);
    logic [127:0] r;
    for (int c = 0; c < 4; c++)
      r[127 - 32*c -: 32] = mixColumn(s[127 - 32*c -: 32]);
    return r;
  endfunction

  // key schedule step, w3 rotated, substituted and salted with rcon feeds word 0
  always_comb begin
    logic [31:0] temp;
    temp = subWord({roundKey[23:0], roundKey[31:24]}) ^ {rcon, 24'h0};
    nextKey[127:96] = roundKey[127:96] ^ temp;
    nextKey[95:64]  = roundKey[95:64] ^ nextKey[127:96];
    nextKey[63:32]  = roundKey[63:32] ^ nextKey[95:64];
    nextKey[31:0]   = roundKey[31:0] ^ nextKey[63:32];
  end

  assign lastRound   = (roundCnt == 4'(`AES_ROUNDS));
  assign shifted     = shiftRows(subBytes(stateReg));
  assign roundOut    = (lastRound ? shifted : mixColumns(shifted)) ^ nextKey;
  assign busy        = (stateQ == aes_pkg::RUN);
  assign cipherValid = busy && lastRound; // round ten result is on resp this cycle
  assign resp.cipher = roundOut;

  always_ff @(posedge clk) begin
    if (rst) begin
      stateQ   <= aes_pkg::IDLE;
      roundCnt <= 4'd0;
    end else if (start) begin
      stateQ   <= aes_pkg::RUN;
      roundCnt <= 4'd1;
    end else if (busy) begin
      if (lastRound) stateQ <= aes_pkg::IDLE;
      roundCnt <= lastRound ? 4'd0 : roundCnt + 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      stateReg <= req.plaintext ^ req.key; // initial AddRoundKey
      roundKey <= req.key;
      rcon     <= 8'h01;
    end else if (busy) begin
      stateReg <= roundOut;
      roundKey <= nextKey;
      rcon     <= xtime(rcon); // 01 02 04 .. 80 1b 36
    end
  end

  // decode must hold off a new block while one is in flight
  startIdleCheck: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

/* aes_tb_model.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 reference model and LFSR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef AES_TB_MODEL_SVH
`define AES_TB_MODEL_SVH

// product in GF(2^8) reduced by the AES polynomial 0x11b
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p, x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) p ^= x;                            // add the shifted multiplicand
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00); // times x, folded back into eight bits
  end
  return p;
endfunction

// S-box built from first principles, no table
function automatic logic [7:0] refSbox(input logic [7:0] a);
  logic [7:0] r, p;
  r = 8'h01;
  p = a;
  for (int i = 1; i < 8; i++) begin
    p = gfMul(p, p); // a raised to 2^i
    r = gfMul(r, p); // accumulates a^254, the inverse, and zero stays zero
  end
  // affine map, the inverse xor four left rotations of itself and 0x63
  return r ^ {r[6:0], r[7]} ^ {r[5:0], r[7:6]} ^ {r[4:0], r[7:5]}
           ^ {r[3:0], r[7:4]} ^ 8'h63;
endfunction

// textbook cipher on a 4x4 byte array, s[r][c] is byte S r,c
function automatic logic [127:0] aesEncrypt(input logic [127:0] key, input logic [127:0] pt);
  logic [31:0]  w [44];  // full key schedule, word 0 of the key first
  logic [7:0]   s [4][4];
  logic [7:0]   t [4][4];
  logic [31:0]  tmp;
  logic [7:0]   rc;
  logic [127:0] ct;
  rc = 8'h01;
  for (int i = 0; i < 44; i++) begin
    if (i < 4) begin
      w[i] = key[127 - 32*i -: 32];
    end else begin
      tmp = w[i-1];
      if (i % 4 == 0) begin // RotWord then SubWord then Rcon
        tmp = {refSbox(tmp[23:16]), refSbox(tmp[15:8]), refSbox(tmp[7:0]),
               refSbox(tmp[31:24])} ^ {rc, 24'h0};
        rc = gfMul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
  end
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
      s[r][c] = pt[127 - 8*(4*c + r) -: 8] ^ w[c][31 - 8*r -: 8];
  for (int rnd = 1; rnd <= 10; rnd++) begin
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        t[r][c] = refSbox(s[r][(c + r) % 4]); // row r taken r columns further on
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++) begin
        if (rnd < 10)
          s[r][c] = gfMul(t[r][c], 8'h02) ^ gfMul(t[(r+1)%4][c], 8'h03)
                    ^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
        else
          s[r][c] = t[r][c]; // last round has no column mixing
        s[r][c] ^= w[4*rnd + c][31 - 8*r -: 8];
      end
  end
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
      ct[127 - 8*(4*c + r) -: 8] = s[r][c];
  return ct;
endfunction

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* aes_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 peripheral testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "aes_config.svh"

module aes_tb;

  localparam int clkPeriod = 8;
  localparam int numTests  = 45; // reset, C.1 vector, 40 random, strobe, double start, SLVERR

  logic clk, rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [`AES_ADDR_W-1:0]   awaddr, araddr;
  logic [`AES_DATA_W-1:0]   wdata, rdata;
  logic [`AES_DATA_W/8-1:0] wstrb;
  logic [1:0]               bresp, rresp;

  logic [31:0] lfsr = 32'h1d1d;
  logic        stallOn;                   // ready stalls drawn from the LFSR when set
  int          checksIssued, checksDone;
  string       nameQ [$];                 // pending checks, one entry per response field
  logic [31:0] gotQ [$];
  logic [31:0] expQ [$];

  `include "aes_tb_model.svh"

  aes_top i_aes_top (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]}; // one step per bit
    end
    return v;
  endfunction

  function automatic int stallCycles();
    logic [31:0] v;
    if (!stallOn) return 0;
    v = takeBits(2); // zero to three cycles
    return int'(v);
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic void expectValue(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
    nameQ.push_back(name);
    gotQ.push_back(got);
    expQ.push_back(exp);
    checksIssued++;
  endfunction

  initial begin : compare
    string       name;
    logic [31:0] got, exp;
    forever begin
      wait (checksDone != checksIssued);
      name = nameQ.pop_front();
      got  = gotQ.pop_front();
      exp  = expQ.pop_front();
      assert (got === exp)
        else failRun($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
      checksDone++;
    end
  end

  task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp);
    int stall;
    stall = stallCycles();
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(negedge clk);
    end while (!(awready && wready)); // both readies high, the transfer lands on the next edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (stall) @(negedge clk);
    bready = 1'b1;
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int stall;
    stall = stallCycles();
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk); // address taken on the edge just passed
    arvalid = 1'b0;
    repeat (stall) @(negedge clk);
    rready = 1'b1;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input logic [1:0] expResp);
    logic [1:0] resp;
    axiWrite(addr, data, strb, resp);
    expectValue($sformatf("bresp@%h", addr), {30'b0, resp}, {30'b0, expResp});
  endtask

  task automatic readReg(input logic [7:0] addr, input logic [31:0] exp,
                         input logic [1:0] expResp);
    logic [31:0] data;
    logic [1:0]  resp;
    axiRead(addr, data, resp);
    expectValue($sformatf("rresp@%h", addr), {30'b0, resp}, {30'b0, expResp});
    expectValue($sformatf("rdata@%h", addr), data, exp);
  endtask

  // with split strobes a word goes in as a random byte mask and then its complement
  task automatic loadWord(input logic [7:0] addr, input logic [31:0] data, input bit split);
    logic [31:0] v;
    logic [3:0]  m;
    m = 4'hf;
    if (split) begin
      v = takeBits(4);
      m = v[3:0];
    end
    writeReg(addr, data, m, `AXI_RESP_OKAY);
    if (m != 4'hf) writeReg(addr, data, ~m, `AXI_RESP_OKAY);
  endtask

  task automatic loadBlock(input logic [127:0] key, input logic [127:0] pt, input bit split);
    for (int i = 0; i < 4; i++) begin
      loadWord(8'(`AES_REG_KEY0 + 4*i), key[127 - 32*i -: 32], split);
      loadWord(8'(`AES_REG_PT0 + 4*i), pt[127 - 32*i -: 32], split);
    end
  endtask

  task automatic finishBlock(input logic [127:0] expCt);
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do begin
      axiRead(`AES_REG_STATUS, data, resp);
      polls++;
    end while (!data[1] && polls < 20);
    assert (data[1])
      else failRun("done bit never set after 20 status reads");
    readReg(`AES_REG_STATUS, 32'h2, `AXI_RESP_OKAY); // done set and busy clear
    for (int i = 0; i < 4; i++)
      readReg(8'(`AES_REG_CT0 + 4*i), expCt[127 - 32*i -: 32], `AXI_RESP_OKAY);
  endtask

  task automatic runBlock(input logic [127:0] key, input logic [127:0] pt,
                          input logic [127:0] expCt, input bit split);
    loadBlock(key, pt, split);
    writeReg(`AES_REG_CTRL, 32'h1, 4'hf, `AXI_RESP_OKAY);
    finishBlock(expCt);
  endtask

  initial begin : stimulus
    logic [127:0] key, pt, mk;
    logic [31:0]  v;
    rst     = 1'b1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    stallOn = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    readReg(`AES_REG_STATUS, 32'h0, `AXI_RESP_OKAY); // idle and cleared after reset
    for (int i = 0; i < 4; i++)
      readReg(8'(`AES_REG_CT0 + 4*i), 32'h0, `AXI_RESP_OKAY);

    key = 128'h000102030405060708090a0b0c0d0e0f; // FIPS-197 appendix C.1
    pt  = 128'h00112233445566778899aabbccddeeff;
    assert (aesEncrypt(key, pt) === 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else failRun("reference model does not reproduce the FIPS-197 C.1 ciphertext");
    runBlock(key, pt, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0);

    stallOn = 1'b1;
    repeat (40) begin
      for (int i = 0; i < 4; i++) key[127 - 32*i -: 32] = takeBits(32);
      for (int i = 0; i < 4; i++) pt[127 - 32*i -: 32] = takeBits(32);
      runBlock(key, pt, aesEncrypt(key, pt), 1'b1);
    end
    stallOn = 1'b0; // the double start below depends on tight write timing

    v = takeBits(32);
    loadBlock(key, pt, 1'b0);
    writeReg(`AES_REG_KEY0, v, 4'b0100, `AXI_RESP_OKAY); // only byte lane 2 lands
    mk = key;
    mk[119:112] = v[23:16];
    writeReg(`AES_REG_CTRL, 32'h1, 4'hf, `AXI_RESP_OKAY);
    finishBlock(aesEncrypt(mk, pt));

    loadBlock(key, pt, 1'b0);
    writeReg(`AES_REG_CTRL, 32'h1, 4'hf, `AXI_RESP_OKAY);
    writeReg(`AES_REG_PT0, ~pt[127:96], 4'hf, `AXI_RESP_OKAY);
    writeReg(`AES_REG_CTRL, 32'h1, 4'hf, `AXI_RESP_OKAY); // lands while the engine is busy
    finishBlock(aesEncrypt(key, pt));

    pt[127:96] = ~pt[127:96]; // plaintext word 0 as the register now holds it
    writeReg(8'h40, 32'hdeadbeef, 4'hf, `AXI_RESP_SLVERR);
    readReg(8'h40, 32'h0, `AXI_RESP_SLVERR);
    writeReg(`AES_REG_CTRL, 32'h1, 4'hf, `AXI_RESP_OKAY); // runs on the stored key and plaintext
    finishBlock(aesEncrypt(key, pt));

    wait (checksDone == checksIssued);
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin : watchdog
    #((numTests * 200 + 500) * clkPeriod);
    failRun("timeout, the test sequence did not finish in time");
  end

endmodule

`default_nettype wire

/* aes_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 AXI4-Lite peripheral top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none
`include "aes_config.svh"

module aes_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      awvalid,
  output logic                           awready,
  input  wire logic [`AES_ADDR_W-1:0]    awaddr,
  input  wire logic                      wvalid,
  output logic                           wready,
  input  wire logic [`AES_DATA_W-1:0]    wdata,
  input  wire logic [`AES_DATA_W/8-1:0]  wstrb,
  output logic                           bvalid,
  input  wire logic                      bready,
  output logic [1:0]                     bresp,
  input  wire logic                      arvalid,
  output logic                           arready,
  input  wire logic [`AES_ADDR_W-1:0]    araddr,
  output logic                           rvalid,
  input  wire logic                      rready,
  output logic [`AES_DATA_W-1:0]         rdata,
  output logic [1:0]                     rresp
);

  logic             start;       // one-cycle job launch from decode
  aes_pkg::aesReqT  req;         // key and plaintext registers
  logic             busy;        // engine is running rounds
  logic             cipherValid; // round ten is done this cycle
  aes_pkg::aesRespT resp;
  logic             done;
  logic [127:0]     ctWords;

  aes_reg_decode regDecode (.*); // bus side, all names match one to one

  aes_round_engine roundEngine (
    .clk, .rst, .start, .req, .busy, .cipherValid, .resp
  );

  aes_result result (
    .clk, .rst, .start, .cipherValid, .resp, .done, .ctWords
  );

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
aes_pkg.sv
aes_reg_decode.sv
aes_round_engine.sv
aes_result.sv
aes_top.sv
aes_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the AES-128 testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module aes_tb -o aes_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/aes_sim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "pass line missing from sim.log"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi
exit 0
